// File: Bender.yml
package:
  name: dcache

sources:
  - target: rtl
    files:
      - source/dcache_cfg_pkg.sv
      - source/dcache_if_pkg.sv
      - source/dcache_arrays.sv
      - source/dcache_lookup_stage.sv
      - source/dcache_access_stage.sv
      - source/dcache_miss_fsm.sv
      - source/dcache_top.sv

  - target: test
    files:
      - verif/dcache_asserts.sv
      - verif/dcache_tb.sv

// File: source/dcache_access_stage.sv
// ==========================================================
// access stage: load extraction, store merge, array writes
// for store hits and refills, miss hand-off and the response
// ==========================================================
`timescale 1ns/1ps

module dcache_access_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       s2_valid_i,
  input  dcache_if_pkg::s2_entry_t   s2_entry_i,
  input  logic                       rsp_ready_i,
  input  logic                       refill_done_i,
  input  dcache_cfg_pkg::line_t      refill_line_i,
  output logic                       s2_ready_o,
  output logic                       rsp_valid_o,
  output dcache_if_pkg::dcache_rsp_t rsp_o,
  output dcache_if_pkg::arr_wr_t     arr_wr_o,
  output logic                       miss_start_o,
  output logic                       wb_needed_o,
  output dcache_cfg_pkg::line_addr_t victim_addr_o,
  output dcache_cfg_pkg::line_t      victim_line_o,
  output dcache_cfg_pkg::line_addr_t fill_addr_o
);
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;

  s2_entry_t s2_q;
  logic      s2_valid_q;
  logic      refilled_q;
  logic      pending;
  logic      is_store;
  logic      store_hit_wr;
  way_t      sel_way;
  idx_t      idx;
  ofs_t      ofs;
  logic [$clog2(WORDS_PER_LINE)-1:0] wsel;
  line_t     base_line;
  line_t     merged_line;
  word_t     word;
  word_t     shifted;
  word_t     wdata_sh;
  logic [3:0] be;
  idx_t      in_idx;
  way_t      in_sel;

  assign idx       = s2_q.s1.req.addr[OFS_WIDTH +: IDX_WIDTH];
  assign ofs       = s2_q.s1.req.addr[OFS_WIDTH-1:0];
  assign wsel      = ofs[OFS_WIDTH-1:2];
  assign is_store  = s2_q.s1.req.op == STORE;
  assign pending   = s2_valid_q && s2_q.miss && !refilled_q;
  assign sel_way   = s2_q.miss ? s2_q.victim_way : s2_q.hit_way;
  assign base_line = (refilled_q || refill_done_i) ? refill_line_i : s2_q.hit_line;
  assign word      = base_line[wsel*4 +: 4];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid_q <= 1'b0;
      refilled_q <= 1'b0;
    end else if (s2_ready_o) begin
      s2_valid_q <= s2_valid_i;
      refilled_q <= 1'b0;
    end else if (refill_done_i) begin
      refilled_q <= 1'b1;
    end
  end

  // a store hit leaving s2 writes on the same edge the next entry
  // arrives, so that entry takes the new line and dirty bit here
  assign in_idx = s2_entry_i.s1.req.addr[OFS_WIDTH +: IDX_WIDTH];
  assign in_sel = s2_entry_i.miss ? s2_entry_i.victim_way : s2_entry_i.hit_way;

  always_ff @(posedge clk) begin
    if (s2_ready_o && s2_valid_i) begin
      s2_q <= s2_entry_i;
      if (arr_wr_o.en && arr_wr_o.idx == in_idx) begin
        if (arr_wr_o.way == in_sel) begin
          s2_q.hit_line <= arr_wr_o.line;
        end
        if (arr_wr_o.way == s2_entry_i.victim_way) begin
          s2_q.victim_meta <= arr_wr_o.meta;
        end
      end
    end
  end

  // store merge, BU/HU stores behave as B/H
  always_comb begin
    wdata_sh = s2_q.s1.req.wdata << {ofs[1:0], 3'b000};
    case (s2_q.s1.req.align)
      ALIGN_B, ALIGN_BU: be = 4'b0001 << ofs[1:0];
      ALIGN_H, ALIGN_HU: be = 4'b0011 << ofs[1:0];
      default:           be = 4'b1111;
    endcase
    merged_line = base_line;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged_line[wsel*4 + b] = wdata_sh[8*b +: 8];
      end
    end
  end

  assign store_hit_wr = s2_valid_q && is_store && !s2_q.miss && !s2_q.s1.ale && rsp_ready_i;

  always_comb begin
    arr_wr_o.en         = store_hit_wr || refill_done_i;
    arr_wr_o.idx        = idx;
    arr_wr_o.way        = sel_way;
    arr_wr_o.tag        = s2_q.s1.req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    arr_wr_o.meta.valid = 1'b1;
    arr_wr_o.meta.dirty = is_store;
    arr_wr_o.line       = is_store ? merged_line : base_line;
    arr_wr_o.dirty_only = !refill_done_i;
  end

  // miss hand-off, held until the refill comes back
  assign miss_start_o  = pending;
  assign wb_needed_o   = s2_q.victim_meta.valid && s2_q.victim_meta.dirty;
  assign victim_addr_o = {s2_q.victim_tag, idx};
  assign victim_line_o = s2_q.hit_line;
  assign fill_addr_o   = s2_q.s1.req.addr[ADDR_WIDTH-1:OFS_WIDTH];

  assign rsp_valid_o = s2_valid_q && !pending;
  assign s2_ready_o  = !s2_valid_q || (rsp_valid_o && rsp_ready_i);

  always_comb begin
    shifted   = word >> {ofs[1:0], 3'b000};
    rsp_o.op  = s2_q.s1.req.op;
    rsp_o.ale = s2_q.s1.ale;
    rsp_o.addr = s2_q.s1.req.addr;
    rsp_o.id  = s2_q.s1.req.id;
    case (s2_q.s1.req.align)
      ALIGN_B:  rsp_o.rdata = {{24{shifted[7]}}, shifted[7:0]};
      ALIGN_BU: rsp_o.rdata = {24'b0, shifted[7:0]};
      ALIGN_H:  rsp_o.rdata = {{16{shifted[15]}}, shifted[15:0]};
      ALIGN_HU: rsp_o.rdata = {16'b0, shifted[15:0]};
      default:  rsp_o.rdata = word;
    endcase
  end

endmodule

// File: source/dcache_arrays.sv
// ==========================================================
// tag, meta, data and PLRU storage of the cache, read with
// one registered index; a same-cycle write is read through
// ==========================================================
`timescale 1ns/1ps

module dcache_arrays (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  dcache_cfg_pkg::idx_t                                rd_idx_i,
  input  dcache_if_pkg::arr_wr_t                              wr_i,
  input  logic                                                plru_we_i,
  input  dcache_cfg_pkg::idx_t                                plru_idx_i,
  input  dcache_cfg_pkg::way_t                                plru_way_i,
  output dcache_cfg_pkg::tag_t  [dcache_cfg_pkg::WAY_NUM-1:0] tags_o,
  output dcache_cfg_pkg::meta_t [dcache_cfg_pkg::WAY_NUM-1:0] metas_o,
  output dcache_cfg_pkg::line_t [dcache_cfg_pkg::WAY_NUM-1:0] lines_o,
  output dcache_cfg_pkg::way_t                                plru_o
);
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;

  tag_t  tag_mem  [WAY_NUM][2**IDX_WIDTH];
  line_t data_mem [WAY_NUM][2**IDX_WIDTH];
  meta_t [WAY_NUM-1:0][2**IDX_WIDTH-1:0] meta_q;
  way_t  [2**IDX_WIDTH-1:0]              plru_q;

  logic [WAY_NUM-1:0] way_wr;

  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      way_wr[w] = wr_i.en && wr_i.way == way_t'(w);
    end
  end

  // tag and data
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAY_NUM; w++) begin
      if (way_wr[w]) begin
        data_mem[w][wr_i.idx] <= wr_i.line;
        if (!wr_i.dirty_only) begin
          tag_mem[w][wr_i.idx] <= wr_i.tag;
        end
      end
      if (way_wr[w] && wr_i.idx == rd_idx_i) begin
        lines_o[w] <= wr_i.line;
        tags_o[w]  <= wr_i.dirty_only ? tag_mem[w][rd_idx_i] : wr_i.tag;
      end else begin
        lines_o[w] <= data_mem[w][rd_idx_i];
        tags_o[w]  <= tag_mem[w][rd_idx_i];
      end
    end
  end

  // meta and plru start out cleared
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q  <= '0;
      plru_q  <= '0;
      metas_o <= '0;
      plru_o  <= '0;
    end else begin
      for (int w = 0; w < WAY_NUM; w++) begin
        if (way_wr[w]) begin
          meta_q[w][wr_i.idx] <= wr_i.meta;
        end
        metas_o[w] <= (way_wr[w] && wr_i.idx == rd_idx_i) ? wr_i.meta
                                                           : meta_q[w][rd_idx_i];
      end
      // point at the way not just used
      if (plru_we_i) begin
        plru_q[plru_idx_i] <= ~plru_way_i;
      end
      plru_o <= (plru_we_i && plru_idx_i == rd_idx_i) ? ~plru_way_i : plru_q[rd_idx_i];
    end
  end

endmodule

// File: source/dcache_cfg_pkg.sv
// ==========================================================
// geometry of the two-way write-back data cache and the
// vector types derived from it, shared by all cache blocks
// ==========================================================
package dcache_cfg_pkg;

  // 2 ways x 16 sets x 16-byte lines
  localparam int WAY_NUM        = 2;
  localparam int IDX_WIDTH      = 4;
  localparam int LINE_BYTES     = 16;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFS_WIDTH      = 4;
  localparam int ADDR_WIDTH     = 32;
  localparam int TAG_WIDTH      = 24;
  localparam int ID_WIDTH       = 4;

  typedef logic [ADDR_WIDTH-1:0]           paddr_t;
  typedef logic [TAG_WIDTH-1:0]            tag_t;
  typedef logic [IDX_WIDTH-1:0]            idx_t;
  typedef logic [OFS_WIDTH-1:0]            ofs_t;
  typedef logic [31:0]                     word_t;
  // byte 0 of the line sits at the lowest address
  typedef logic [LINE_BYTES-1:0][7:0]      line_t;
  typedef logic [$clog2(WAY_NUM)-1:0]      way_t;
  typedef logic [ID_WIDTH-1:0]             req_id_t;
  // address without the byte offset
  typedef logic [ADDR_WIDTH-OFS_WIDTH-1:0] line_addr_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } meta_t;

endpackage

// File: source/dcache_if_pkg.sv
// ==========================================================
// request, response and memory port types of the data cache,
// plus the pipeline stage registers and the array write bus
// ==========================================================
package dcache_if_pkg;

  typedef enum logic {
    LOAD,
    STORE
  } mem_op_e;

  typedef enum logic [2:0] {
    ALIGN_B,
    ALIGN_H,
    ALIGN_W,
    ALIGN_BU,
    ALIGN_HU
  } align_e;

  // core side
  typedef struct packed {
    mem_op_e                 op;
    align_e                  align;
    dcache_cfg_pkg::paddr_t  addr;
    dcache_cfg_pkg::word_t   wdata;
    dcache_cfg_pkg::req_id_t id;
  } dcache_req_t;

  typedef struct packed {
    mem_op_e                 op;
    logic                    ale;
    dcache_cfg_pkg::word_t   rdata;
    dcache_cfg_pkg::paddr_t  addr;
    dcache_cfg_pkg::req_id_t id;
  } dcache_rsp_t;

  // memory side, one whole line per transaction
  typedef struct packed {
    logic                       we;
    dcache_cfg_pkg::line_addr_t addr;
    dcache_cfg_pkg::line_t      wdata;
  } mem_req_t;

  // ==========================================================
  // pipeline registers
  // ==========================================================
  typedef struct packed {
    dcache_req_t req;
    logic        ale;
  } s1_entry_t;

  typedef struct packed {
    s1_entry_t             s1;
    logic                  miss;
    dcache_cfg_pkg::way_t  hit_way;
    dcache_cfg_pkg::way_t  victim_way;
    dcache_cfg_pkg::meta_t victim_meta;
    dcache_cfg_pkg::tag_t  victim_tag;
    // line of the hit way, or of the victim on a miss
    dcache_cfg_pkg::line_t hit_line;
  } s2_entry_t;

  typedef struct packed {
    logic                  en;
    dcache_cfg_pkg::idx_t  idx;
    dcache_cfg_pkg::way_t  way;
    dcache_cfg_pkg::tag_t  tag;
    dcache_cfg_pkg::meta_t meta;
    dcache_cfg_pkg::line_t line;
    // store hit, tag left untouched
    logic                  dirty_only;
  } arr_wr_t;

endpackage

// File: source/dcache_lookup_stage.sv
// ==========================================================
// accept and lookup stages: alignment check on the incoming
// request, tag compare against the array outputs, PLRU victim
// choice and the entry handed on to the access stage
// ==========================================================
`timescale 1ns/1ps

module dcache_lookup_stage (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                req_valid_i,
  input  dcache_if_pkg::dcache_req_t                          req_i,
  input  logic                                                s2_ready_i,
  input  dcache_cfg_pkg::tag_t  [dcache_cfg_pkg::WAY_NUM-1:0] tags_i,
  input  dcache_cfg_pkg::meta_t [dcache_cfg_pkg::WAY_NUM-1:0] metas_i,
  input  dcache_cfg_pkg::line_t [dcache_cfg_pkg::WAY_NUM-1:0] lines_i,
  input  dcache_cfg_pkg::way_t                                plru_i,
  output logic                                                req_ready_o,
  output dcache_cfg_pkg::idx_t                                rd_idx_o,
  output logic                                                s2_valid_o,
  output dcache_if_pkg::s2_entry_t                            s2_entry_o,
  output logic                                                plru_we_o,
  output dcache_cfg_pkg::idx_t                                plru_idx_o,
  output dcache_cfg_pkg::way_t                                plru_way_o
);
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;

  s1_entry_t          s1_q;
  logic               s1_valid_q;
  logic               ale;
  tag_t               s1_tag;
  idx_t               s1_idx;
  logic [WAY_NUM-1:0] hit_vec;
  logic               miss;
  way_t               hit_way;
  way_t               sel_way;

  // ==========================================================
  // stage 0
  // ==========================================================
  always_comb begin
    case (req_i.align)
      ALIGN_H, ALIGN_HU: ale = req_i.addr[0];
      ALIGN_W:           ale = |req_i.addr[1:0];
      default:           ale = 1'b0;
    endcase
  end

  assign req_ready_o = !s1_valid_q || s2_ready_i;

  // held index while s1 stalls, so the arrays keep reading its set
  assign rd_idx_o = req_ready_o ? req_i.addr[OFS_WIDTH +: IDX_WIDTH] : s1_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      s1_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      s1_q.req <= req_i;
      s1_q.ale <= ale;
    end
  end

  // ==========================================================
  // stage 1
  // ==========================================================
  assign s1_tag = s1_q.req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign s1_idx = s1_q.req.addr[OFS_WIDTH +: IDX_WIDTH];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      hit_vec[w] = metas_i[w].valid && tags_i[w] == s1_tag;
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
    end
    miss    = ~|hit_vec;
    sel_way = miss ? plru_i : hit_way;
  end

  always_comb begin
    s2_entry_o.s1          = s1_q;
    // misaligned requests never go to memory
    s2_entry_o.miss        = miss && !s1_q.ale;
    s2_entry_o.hit_way     = hit_way;
    s2_entry_o.victim_way  = plru_i;
    s2_entry_o.victim_meta = metas_i[plru_i];
    s2_entry_o.victim_tag  = tags_i[plru_i];
    s2_entry_o.hit_line    = lines_i[sel_way];
  end

  assign s2_valid_o = s1_valid_q;

  // touch the plru once, as the entry moves on
  assign plru_we_o  = s1_valid_q && s2_ready_i && !s1_q.ale;
  assign plru_idx_o = s1_idx;
  assign plru_way_o = sel_way;

endmodule

// File: source/dcache_miss_fsm.sv
// ==========================================================
// miss engine: optional write-back of the dirty victim, then
// the refill, each as one four-phase req/ack transaction
// ==========================================================
`timescale 1ns/1ps

module dcache_miss_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       miss_start_i,
  input  logic                       wb_needed_i,
  input  dcache_cfg_pkg::line_addr_t victim_addr_i,
  input  dcache_cfg_pkg::line_t      victim_line_i,
  input  dcache_cfg_pkg::line_addr_t fill_addr_i,
  input  logic                       mem_ack_i,
  input  dcache_cfg_pkg::line_t      mem_rdata_i,
  output logic                       mem_req_valid_o,
  output dcache_if_pkg::mem_req_t    mem_req_o,
  output logic                       refill_done_o,
  output dcache_cfg_pkg::line_t      refill_line_o
);
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WB_REQ,
    WB_WAIT,
    RF_REQ,
    RF_WAIT,
    DONE
  } miss_state_e;

  miss_state_e state_q;
  miss_state_e state_d;

  // *_REQ holds req until ack, *_WAIT waits for ack to drop
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (miss_start_i) begin
          state_d = wb_needed_i ? WB_REQ : RF_REQ;
        end
      end
      WB_REQ: begin
        if (mem_ack_i) begin
          state_d = WB_WAIT;
        end
      end
      WB_WAIT: begin
        if (!mem_ack_i) begin
          state_d = RF_REQ;
        end
      end
      RF_REQ: begin
        if (mem_ack_i) begin
          state_d = RF_WAIT;
        end
      end
      RF_WAIT: begin
        if (!mem_ack_i) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // read data is only valid while ack is high
  always_ff @(posedge clk) begin
    if (state_q == RF_REQ && mem_ack_i) begin
      refill_line_o <= mem_rdata_i;
    end
  end

  assign mem_req_valid_o = state_q == WB_REQ || state_q == RF_REQ;
  assign mem_req_o.we    = state_q inside {WB_REQ, WB_WAIT};
  assign mem_req_o.addr  = mem_req_o.we ? victim_addr_i : fill_addr_i;
  assign mem_req_o.wdata = victim_line_i;
  assign refill_done_o   = state_q == DONE;

endmodule

// File: source/dcache_top.sv
// ==========================================================
// two-way write-back data cache for the load/store unit
// valid/ready request and response on the core side, one
// line per four-phase req/ack transaction on the memory side
// ==========================================================
`timescale 1ns/1ps

module dcache_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_valid_i,
  input  dcache_if_pkg::dcache_req_t req_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output dcache_if_pkg::dcache_rsp_t rsp_o,
  input  logic                       rsp_ready_i,
  output logic                       mem_req_valid_o,
  output dcache_if_pkg::mem_req_t    mem_req_o,
  input  logic                       mem_ack_i,
  input  dcache_cfg_pkg::line_t      mem_rdata_i
);
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;

  logic                 s2_ready;
  logic                 s2_valid;
  s2_entry_t            s2_entry;
  idx_t                 rd_idx;
  tag_t  [WAY_NUM-1:0]  tags;
  meta_t [WAY_NUM-1:0]  metas;
  line_t [WAY_NUM-1:0]  lines;
  way_t                 plru;
  logic                 plru_we;
  idx_t                 plru_idx;
  way_t                 plru_way;
  arr_wr_t              arr_wr;
  logic                 miss_start;
  logic                 wb_needed;
  line_addr_t           victim_addr;
  line_addr_t           fill_addr;
  line_t                victim_line;
  line_t                refill_line;
  logic                 refill_done;

  dcache_lookup_stage u_lookup (
    .clk, .rst_n, .req_valid_i, .req_i, .req_ready_o,
    .s2_ready_i (s2_ready),    .tags_i     (tags),       .metas_i    (metas),
    .lines_i    (lines),       .plru_i     (plru),       .rd_idx_o   (rd_idx),
    .s2_valid_o (s2_valid),    .s2_entry_o (s2_entry),   .plru_we_o  (plru_we),
    .plru_idx_o (plru_idx),    .plru_way_o (plru_way)
  );

  dcache_access_stage u_access (
    .clk, .rst_n, .rsp_ready_i, .rsp_valid_o, .rsp_o,
    .s2_valid_i     (s2_valid),    .s2_entry_i    (s2_entry),
    .refill_done_i  (refill_done), .refill_line_i (refill_line),
    .s2_ready_o     (s2_ready),    .arr_wr_o      (arr_wr),
    .miss_start_o   (miss_start),  .wb_needed_o   (wb_needed),
    .victim_addr_o  (victim_addr), .victim_line_o (victim_line),
    .fill_addr_o    (fill_addr)
  );

  dcache_arrays u_arrays (
    .clk, .rst_n,
    .rd_idx_i   (rd_idx),   .wr_i       (arr_wr),   .plru_we_i  (plru_we),
    .plru_idx_i (plru_idx), .plru_way_i (plru_way), .tags_o     (tags),
    .metas_o    (metas),    .lines_o    (lines),    .plru_o     (plru)
  );

  dcache_miss_fsm u_miss (
    .clk, .rst_n, .mem_ack_i, .mem_rdata_i, .mem_req_valid_o, .mem_req_o,
    .miss_start_i  (miss_start),  .wb_needed_i   (wb_needed),
    .victim_addr_i (victim_addr), .victim_line_i (victim_line),
    .fill_addr_i   (fill_addr),   .refill_done_o (refill_done),
    .refill_line_o (refill_line)
  );

endmodule

// File: sources.f
source/dcache_cfg_pkg.sv
source/dcache_if_pkg.sv
source/dcache_arrays.sv
source/dcache_lookup_stage.sv
source/dcache_access_stage.sv
source/dcache_miss_fsm.sv
source/dcache_top.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

// File: verif/dcache_asserts.sv
// ==========================================================
// concurrent protocol checks for the data cache, bound to the
// top level: core handshake, four-phase memory port, the limit
// on outstanding requests and the quiet period after reset
// ==========================================================
`timescale 1ns/1ps

module dcache_asserts (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       req_valid_i,
  input logic                       req_ready_o,
  input logic                       rsp_valid_o,
  input dcache_if_pkg::dcache_rsp_t rsp_o,
  input logic                       rsp_ready_i,
  input logic                       mem_req_valid_o,
  input dcache_if_pkg::mem_req_t    mem_req_o,
  input logic                       mem_ack_i
);

  logic       seen_req_q;
  logic [2:0] outstanding_q;
  // raised by any failing property, watched by the testbench
  logic       violation = 1'b0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_req_q    <= 1'b0;
      outstanding_q <= '0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        seen_req_q <= 1'b1;
      end
      case ({req_valid_i && req_ready_o, rsp_valid_o && rsp_ready_i})
        2'b10:   outstanding_q <= outstanding_q + 3'd1;
        2'b01:   outstanding_q <= outstanding_q - 3'd1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // ==========================================================
  // core side
  // ==========================================================
  quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_req_q |-> !rsp_valid_o && !mem_req_valid_o)
    else begin
      $error("response or memory request before the first accepted request");
      violation = 1'b1;
    end

  rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else begin
      $error("response changed or dropped while stalled");
      violation = 1'b1;
    end

  two_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= 3'd2)
    else begin
      $error("more than two requests outstanding");
      violation = 1'b1;
    end

  // ==========================================================
  // memory side, four-phase req/ack
  // ==========================================================
  req_rise_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req_valid_o) |-> !mem_ack_i)
    else begin
      $error("memory request raised while ack still high");
      violation = 1'b1;
    end

  req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid_o && !mem_ack_i |=> mem_req_valid_o && $stable(mem_req_o))
    else begin
      $error("memory request dropped or changed before ack");
      violation = 1'b1;
    end

  req_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid_o && mem_ack_i |=> !mem_req_valid_o)
    else begin
      $error("memory request still high after ack");
      violation = 1'b1;
    end

endmodule

// File: verif/dcache_tb.sv
// ==========================================================
// testbench of the data cache with random loads and stores
// from an LCG, a four-phase line memory, and a byte model of
// the memory contents that predicts every response
// ==========================================================
`timescale 1ns/1ps

module dcache_tb;
  import dcache_cfg_pkg::*;
  import dcache_if_pkg::*;

  localparam int NUM_REQS   = 400;
  // 400 requests x 60 cycles worst case, twice over
  localparam int MAX_CYCLES = 2 * NUM_REQS * 60;
  localparam int MEM_BYTES  = 1024;
  localparam int MEM_LINES  = MEM_BYTES / LINE_BYTES;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  dcache_req_t req;
  logic        req_ready;
  logic        rsp_valid;
  dcache_rsp_t rsp;
  logic        rsp_ready;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_ack;
  line_t       mem_rdata;

  logic [31:0] lcg_state = 32'h59f41ba4;
  logic [7:0]  mem_bytes [MEM_BYTES];
  logic [7:0]  ref_bytes [MEM_BYTES];
  logic        resident  [MEM_LINES];
  dcache_rsp_t expect_q  [$];
  int          sent;
  int          done;
  int          cycles;
  int          mem_delay;
  int          txn_since_rsp;
  logic        mem_req_prev;

  dcache_top UUT (
    .clk, .rst_n,
    .req_valid_i     (req_valid),     .req_i       (req),     .req_ready_o (req_ready),
    .rsp_valid_o     (rsp_valid),     .rsp_o       (rsp),     .rsp_ready_i (rsp_ready),
    .mem_req_valid_o (mem_req_valid), .mem_req_o   (mem_req),
    .mem_ack_i       (mem_ack),       .mem_rdata_i (mem_rdata)
  );

  bind dcache_top dcache_asserts u_asserts (
    .clk, .rst_n, .req_valid_i, .req_ready_o, .rsp_valid_o, .rsp_o, .rsp_ready_i,
    .mem_req_valid_o, .mem_req_o, .mem_ack_i
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================
  // helpers
  // ==========================================================
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
  endfunction

  function automatic int access_size(align_e al);
    case (al)
      ALIGN_H, ALIGN_HU: return 2;
      ALIGN_W:           return 4;
      default:           return 1;
    endcase
  endfunction

  function automatic logic is_misaligned(align_e al, paddr_t a);
    return (a[1:0] & 2'(access_size(al) - 1)) != 2'b00;
  endfunction

  // little-endian bytes from the model extended by size
  function automatic word_t load_value(align_e al, paddr_t a);
    word_t raw;
    raw = '0;
    for (int k = 0; k < access_size(al); k++) begin
      raw[8*k +: 8] = ref_bytes[int'(a[9:0]) + k];
    end
    case (al)
      ALIGN_B: return {{24{raw[7]}}, raw[7:0]};
      ALIGN_H: return {{16{raw[15]}}, raw[15:0]};
      default: return raw;
    endcase
  endfunction

  function automatic dcache_req_t make_request(int n);
    dcache_req_t r;
    logic [1:0]  tag_sel;
    idx_t        idx;
    ofs_t        ofs;
    r.id    = req_id_t'(n);
    r.wdata = next_rand();
    if (n < 6) begin
      // three tags of set 5 stored and read back after eviction
      r.op    = (n < 3) ? STORE : LOAD;
      r.align = ALIGN_W;
      tag_sel = 2'(n % 3);
      idx     = 4'd5;
      ofs     = 4'd8;
    end else begin
      r.op    = (rand_below(2) == 0) ? LOAD : STORE;
      r.align = align_e'(3'(rand_below(5)));
      tag_sel = 2'(rand_below(3));
      idx     = idx_t'(rand_below(16));
      ofs     = ofs_t'(rand_below(16));
      // one request in eight keeps its drawn offset
      if (rand_below(8) != 0) begin
        ofs[1:0] = ofs[1:0] & ~2'(access_size(r.align) - 1);
      end
    end
    r.addr = {22'b0, tag_sel, idx, ofs};
    return r;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // ==========================================================
  // per-cycle work sampled before the edge takes effect
  // ==========================================================
  task automatic record_accept(input dcache_req_t r);
    dcache_rsp_t e;
    int          base;
    base    = int'(r.addr[9:0]);
    e.op    = r.op;
    e.addr  = r.addr;
    e.id    = r.id;
    e.ale   = is_misaligned(r.align, r.addr);
    e.rdata = '0;
    if (!e.ale && r.op == LOAD) begin
      e.rdata = load_value(r.align, r.addr);
    end
    if (!e.ale && r.op == STORE) begin
      for (int k = 0; k < access_size(r.align); k++) begin
        ref_bytes[base + k] = r.wdata[8*k +: 8];
      end
    end
    expect_q.push_back(e);
  endtask

  task automatic check_response();
    dcache_rsp_t e;
    if (mem_req_valid && !mem_req_prev) begin
      txn_since_rsp++;
    end
    mem_req_prev = mem_req_valid;
    if (rsp_valid && rsp_ready) begin
      if (expect_q.size() == 0) begin
        fail_run("response arrived with no request outstanding");
      end
      e = expect_q.pop_front();
      assert (rsp.id == e.id && rsp.op == e.op && rsp.addr == e.addr)
        else fail_run($sformatf(
          "FAILED at %0d ns: response id %0d addr %h, expected id %0d addr %h",
          $time, rsp.id, rsp.addr, e.id, e.addr));
      assert (rsp.ale == e.ale)
        else fail_run($sformatf("FAILED at %0d ns: id %0d ale %0b, expected %0b",
                                $time, rsp.id, rsp.ale, e.ale));
      if (e.ale) begin
        assert (txn_since_rsp == 0)
          else fail_run($sformatf("FAILED at %0d ns: misaligned id %0d went to memory",
                                  $time, e.id));
      end else if (e.op == LOAD) begin
        assert (rsp.rdata == e.rdata)
          else fail_run($sformatf(
            "FAILED at %0d ns: load id %0d addr %h data %h, expected %h",
            $time, e.id, e.addr, rsp.rdata, e.rdata));
      end
      txn_since_rsp = 0;
      done++;
    end
  endtask

  // line memory with a random delay before each ack
  task automatic serve_memory();
    line_t line_buf;
    int    ln;
    ln = int'(mem_req.addr[5:0]);
    if (!mem_ack && mem_req_valid) begin
      if (mem_delay > 0) begin
        mem_delay--;
      end else begin
        if (mem_req.addr[27:6] != '0) begin
          fail_run($sformatf("memory access outside the test range, line %h", mem_req.addr));
        end
        if (mem_req.we) begin
          assert (resident[ln])
            else fail_run($sformatf("FAILED at %0d ns: write-back of line %h never refilled",
                                    $time, mem_req.addr));
          resident[ln] = 1'b0;
          for (int b = 0; b < LINE_BYTES; b++) begin
            mem_bytes[ln*LINE_BYTES + b] = mem_req.wdata[b];
          end
        end else begin
          resident[ln] = 1'b1;
          for (int b = 0; b < LINE_BYTES; b++) begin
            line_buf[b] = mem_bytes[ln*LINE_BYTES + b];
          end
          mem_rdata <= line_buf;
        end
        mem_ack <= 1'b1;
      end
    end else if (mem_ack && !mem_req_valid) begin
      mem_ack   <= 1'b0;
      mem_delay = rand_below(4);
    end
  endtask

  task automatic drive_request();
    if (req_valid && req_ready) begin
      record_accept(req);
      sent++;
    end
    if (!req_valid || req_ready) begin
      if (sent < NUM_REQS && rand_below(4) != 0) begin
        req       <= make_request(sent);
        req_valid <= 1'b1;
      end else begin
        req_valid <= 1'b0;
      end
    end
    rsp_ready <= (rand_below(4) != 0);
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================
  initial begin
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    rsp_ready     = 1'b0;
    mem_ack       = 1'b0;
    mem_rdata     = '0;
    sent          = 0;
    done          = 0;
    cycles        = 0;
    mem_delay     = 0;
    txn_since_rsp = 0;
    mem_req_prev  = 1'b0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem_bytes[a] = 8'(next_rand() >> 16);
      ref_bytes[a] = mem_bytes[a];
    end
    for (int l = 0; l < MEM_LINES; l++) begin
      resident[l] = 1'b0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    while (done < NUM_REQS && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
      if (UUT.u_asserts.violation) begin
        fail_run("a protocol assertion on the cache ports fired");
      end
      check_response();
      serve_memory();
      drive_request();
    end
    // properties sampled on the last edge have settled by the falling edge
    @(negedge clk);
    if (UUT.u_asserts.violation) begin
      fail_run("a protocol assertion on the cache ports fired");
    end else if (done == NUM_REQS) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run($sformatf("timeout: %0d of %0d responses after %0d cycles",
                         done, NUM_REQS, cycles));
    end
  end

endmodule
